// ==== verilog.f ====
+incdir+sim
hw/mgr_cfg_pkg.sv
hw/mgr_msg_pkg.sv
hw/cmd_dispatch_stage.sv
hw/completion_stage.sv
hw/taskwait_stage.sv
hw/task_manager_top.sv
sim/tb_task_manager.sv

// ==== Makefile ====
TOOL     := verilator
TOP      := tb_task_manager
FILELIST := verilog.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
LOG      := sim.log
FAIL_MSG := Simulation finished: FAIL

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/task_manager_tests.svh ====
// Included inside tb_task_manager; tests assume creator 3 has no surplus finishes before test 5
`ifndef TASK_MANAGER_TESTS_SVH
`define TASK_MANAGER_TESTS_SVH

function automatic int pick_random(input int n);
    return {$random(seed)} % n;
endfunction

task automatic tick();
    @(posedge aclk);
    #0.5;
endtask

task automatic compare_cmd(input mgr_msg_pkg::task_cmd_t got,
                           input mgr_msg_pkg::task_cmd_t exp, input string what);
    if (got !== exp) begin
        $display("FAILED at %0t: %s: got acc %0d creator %0d task %h", $time, what,
            got.acc_id, got.creator_id, got.task_id);
        $display("    expected acc %0d creator %0d task %h",
            exp.acc_id, exp.creator_id, exp.task_id);
        errors++;
    end
endtask

task automatic compare_ack(input mgr_msg_pkg::tw_ack_t got,
                           input mgr_msg_pkg::tw_ack_t exp, input string what);
    if (got !== exp) begin
        $display("FAILED at %0t: %s: got creator %0d, expected creator %0d", $time, what,
            got.creator_id, exp.creator_id);
        errors++;
    end
endtask

task automatic send_cmd(input int acc, input int creator, input int tid);
    mgr_msg_pkg::task_cmd_t c;
    c.acc_id = acc[mgr_cfg_pkg::ACC_BITS-1:0];
    c.creator_id = creator[mgr_cfg_pkg::CREATOR_BITS-1:0];
    c.task_id = tid[mgr_cfg_pkg::TASK_ID_BITS-1:0];
    cmd_in = c;
    cmd_in_valid = 1'b1;
    #1;
    while (!cmd_in_ready) begin
        @(posedge aclk);
        #1.5;
    end
    tick();
    cmd_in_valid = 1'b0;
    exp_q[acc].push_back(c);
    total_sent++;
endtask

task automatic send_req(input int creator, input int count);
    tw_req.creator_id = creator[mgr_cfg_pkg::CREATOR_BITS-1:0];
    tw_req.count = count[mgr_cfg_pkg::CNT_BITS-1:0];
    tw_req_valid = 1'b1;
    #1;
    // Ready is low while a finish takes the message slot
    while (!tw_req_ready) begin
        @(posedge aclk);
        #1.5;
    end
    tick();
    tw_req_valid = 1'b0;
endtask

task automatic take_ack(input int creator, input int count, input int hold);
    mgr_msg_pkg::tw_ack_t exp;
    mgr_msg_pkg::tw_ack_t first;
    int n;
    exp.creator_id = creator[mgr_cfg_pkg::CREATOR_BITS-1:0];
    n = 0;
    while (!tw_ack_valid && n < WAIT_LIMIT) begin
        tick();
        n++;
    end
    if (!tw_ack_valid) begin
        $display("No taskwait acknowledge for creator %0d after %0d cycles", creator, n);
        errors++;
        return;
    end
    if (model_cnt[creator] < count) begin
        $display("FAILED at %0t: acknowledge for creator %0d after only %0d of %0d finishes",
            $time, creator, model_cnt[creator], count);
        errors++;
    end
    compare_ack(tw_ack, exp, "taskwait acknowledge");
    first = tw_ack;
    repeat (hold) begin
        tick();
        if (!tw_ack_valid) begin
            $display("Acknowledge dropped while tw_ack_ready was low at %0t", $time);
            errors++;
        end
        compare_ack(tw_ack, first, "acknowledge under back-pressure");
    end
    tw_ack_ready = 1'b1;
    tick();
    tw_ack_ready = 1'b0;
    model_cnt[creator] -= count;
endtask

function automatic bit busy_any();
    for (int a = 0; a < mgr_cfg_pkg::NUM_ACCS; a++) begin
        if (inflight[a]) begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

task automatic wait_drain();
    int n;
    n = 0;
    #1;
    while ((total_disp != total_sent || busy_any()) && n < WAIT_LIMIT) begin
        @(posedge aclk);
        #1.5;
        n++;
    end
    if (n == WAIT_LIMIT) begin
        $display("Commands still queued or running after %0d cycles", n);
        errors++;
    end
    // Let the last finish messages reach the taskwait stage
    repeat (4) tick();
endtask

task automatic check_order(input string what);
    for (int a = 0; a < mgr_cfg_pkg::NUM_ACCS; a++) begin
        if (disp_q[a].size() != exp_q[a].size()) begin
            $display("Accelerator %0d received %0d commands, %0d were sent", a,
                disp_q[a].size(), exp_q[a].size());
            errors++;
        end else begin
            for (int i = 0; i < exp_q[a].size(); i++) begin
                compare_cmd(disp_q[a][i], exp_q[a][i], what);
            end
        end
        disp_q[a].delete();
        exp_q[a].delete();
    end
endtask

task automatic finish_test(input string name, input int err_start);
    if (errors == err_start) begin
        n_pass++;
        $display("Test %s: passed", name);
    end else begin
        n_fail++;
        $display("Test %s: %0d errors", name, errors - err_start);
    end
endtask

task automatic test_single_task();
    int err_start;
    err_start = errors;
    rand_delay = 1'b0;
    delay_max = 3;
    send_cmd(2, 1, 16'h1234);
    wait_drain();
    check_order("single task dispatch");
    send_req(1, 1);
    take_ack(1, 1, 0);
    finish_test("single_task", err_start);
endtask

task automatic test_subqueue_fill();
    int err_start;
    err_start = errors;
    hold_done = 1'b1;
    delay_max = 2;
    // One command goes out to the accelerator, the next eight fill the subqueue
    for (int i = 0; i < mgr_cfg_pkg::SUBQUEUE_LEN + 1; i++) begin
        send_cmd(0, i % 3, 16'h0200 + i);
    end
    cmd_in.acc_id = '0;
    cmd_in.creator_id = '0;
    cmd_in.task_id = 16'h0209;
    cmd_in_valid = 1'b1;
    #1;
    if (cmd_in_ready) begin
        $display("cmd_in_ready stayed high with subqueue 0 full at %0t", $time);
        errors++;
    end
    hold_done = 1'b0;
    tick();
    send_cmd(0, 0, 16'h0209);
    wait_drain();
    check_order("subqueue fill order");
    finish_test("subqueue_fill", err_start);
endtask

task automatic test_credit_rule();
    int err_start;
    err_start = errors;
    rand_delay = 1'b1;
    delay_max = 6;
    for (int i = 0; i < 6; i++) begin
        send_cmd(3, i % 3, 16'h0300 + i);
    end
    wait_drain();
    check_order("credit rule order");
    finish_test("credit_rule", err_start);
endtask

task automatic test_parallel_dispatch();
    int err_start;
    err_start = errors;
    hold_done = 1'b1;
    for (int i = 0; i < 12; i++) begin
        send_cmd(i % mgr_cfg_pkg::NUM_ACCS, i % 3, 16'h0400 + i);
    end
    rand_delay = 1'b1;
    delay_max = 4;
    hold_done = 1'b0;
    wait_drain();
    check_order("parallel dispatch");
    finish_test("parallel_dispatch", err_start);
endtask

task automatic test_taskwait_backpressure();
    int err_start;
    err_start = errors;
    rand_delay = 1'b0;
    delay_max = 2;
    hold_done = 1'b1;
    for (int i = 0; i < 4; i++) begin
        send_cmd(1, 3, 16'h0500 + i);
    end
    send_req(3, 3);
    repeat (10) tick();
    if (tw_ack_valid) begin
        $display("Acknowledge appeared before any task finished at %0t", $time);
        errors++;
    end
    hold_done = 1'b0;
    take_ack(3, 3, 6);
    wait_drain();
    // The fourth finish is surplus and covers this request
    send_req(3, 1);
    take_ack(3, 1, 0);
    check_order("taskwait test dispatch");
    finish_test("taskwait_backpressure", err_start);
endtask

task automatic test_random_mix();
    int err_start;
    int c;
    int count;
    err_start = errors;
    rand_delay = 1'b1;
    delay_max = 8;
    for (int i = 0; i < 24; i++) begin
        send_cmd(pick_random(mgr_cfg_pkg::NUM_ACCS), pick_random(mgr_cfg_pkg::NUM_CREATORS),
            pick_random(65536));
        c = pick_random(mgr_cfg_pkg::NUM_CREATORS);
        if (i % 8 == 7 && model_cnt[c] > 0) begin
            count = 1 + pick_random(model_cnt[c]);
            send_req(c, count);
            take_ack(c, count, pick_random(3));
        end
    end
    wait_drain();
    check_order("random mix dispatch");
    for (int k = 0; k < mgr_cfg_pkg::NUM_CREATORS; k++) begin
        if (model_cnt[k] > 0) begin
            count = 1 + pick_random(model_cnt[k]);
            send_req(k, count);
            take_ack(k, count, pick_random(3));
        end
    end
    finish_test("random_mix", err_start);
endtask

`endif

// ==== sim/tb_task_manager.sv ====
// Directed testbench; assumes mgr_cfg_pkg sizes and at most one acc_done pulse per cycle
`timescale 1ns/100ps

module tb_task_manager;

    localparam real CLK_PERIOD = 4.0;
    localparam int RESET_CYCLES = 8;
    // Per-test cycle budgets in run order
    localparam int BUDGET_CYCLES = 200 + 400 + 300 + 400 + 400 + 1500;
    localparam int MARGIN_CYCLES = 200;
    localparam int WAIT_LIMIT = 400;

    logic                   aclk;
    logic                   rst_n;
    logic                   cmd_in_valid;
    logic                   cmd_in_ready;
    mgr_msg_pkg::task_cmd_t cmd_in;
    logic                   acc_cmd_valid;
    mgr_msg_pkg::task_cmd_t acc_cmd;
    logic                   acc_done_valid;
    mgr_msg_pkg::acc_done_t acc_done;
    logic                   tw_req_valid;
    logic                   tw_req_ready;
    mgr_msg_pkg::tw_req_t   tw_req;
    logic                   tw_ack_valid;
    logic                   tw_ack_ready;
    mgr_msg_pkg::tw_ack_t   tw_ack;

    // Accelerator model and reference state
    mgr_msg_pkg::task_cmd_t               disp_q [mgr_cfg_pkg::NUM_ACCS][$];
    mgr_msg_pkg::task_cmd_t               exp_q  [mgr_cfg_pkg::NUM_ACCS][$];
    bit                                   inflight    [mgr_cfg_pkg::NUM_ACCS];
    int                                   wait_cnt    [mgr_cfg_pkg::NUM_ACCS];
    logic [mgr_cfg_pkg::CREATOR_BITS-1:0] run_creator [mgr_cfg_pkg::NUM_ACCS];
    int                                   model_cnt   [mgr_cfg_pkg::NUM_CREATORS];
    bit                                   hold_done;
    bit                                   rand_delay;
    int                                   delay_max;
    int                                   total_sent;
    int                                   total_disp;
    int                                   errors;
    int                                   n_pass;
    int                                   n_fail;
    integer                               seed;

    task_manager_top DUT (.*);

    `include "task_manager_tests.svh"

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2.0) aclk = ~aclk;
    end

    // Records dispatches at the falling edge, pulses acc_done after the chosen delay
    initial begin
        acc_done_valid = 1'b0;
        acc_done = '0;
        forever begin
            @(negedge aclk);
            if (rst_n && acc_cmd_valid) begin
                if (inflight[acc_cmd.acc_id]) begin
                    $display("Accelerator %0d got a new command before finishing at %0t",
                        acc_cmd.acc_id, $time);
                    errors++;
                end
                disp_q[acc_cmd.acc_id].push_back(acc_cmd);
                inflight[acc_cmd.acc_id] = 1'b1;
                run_creator[acc_cmd.acc_id] = acc_cmd.creator_id;
                wait_cnt[acc_cmd.acc_id] = rand_delay ? 1 + pick_random(delay_max) : delay_max;
                total_disp++;
            end
            @(posedge aclk);
            #0.5;
            acc_done_valid = 1'b0;
            for (int a = 0; a < mgr_cfg_pkg::NUM_ACCS; a++) begin
                if (inflight[a] && wait_cnt[a] > 0) begin
                    wait_cnt[a]--;
                end else if (inflight[a] && !hold_done && !acc_done_valid) begin
                    acc_done_valid = 1'b1;
                    acc_done.acc_id = a[mgr_cfg_pkg::ACC_BITS-1:0];
                    inflight[a] = 1'b0;
                    model_cnt[run_creator[a]]++;
                end
            end
        end
    end

    initial begin
        seed = 96582;
        rst_n = 1'b0;
        cmd_in_valid = 1'b0;
        cmd_in = '0;
        tw_req_valid = 1'b0;
        tw_req = '0;
        tw_ack_ready = 1'b0;
        hold_done = 1'b0;
        rand_delay = 1'b0;
        delay_max = 3;
        repeat (RESET_CYCLES) @(posedge aclk);
        #0.5;
        rst_n = 1'b1;
        tick();
        test_single_task();
        test_subqueue_fill();
        test_credit_rule();
        test_parallel_dispatch();
        test_taskwait_backpressure();
        test_random_mix();
        $display("Tests passed: %0d  Tests failed: %0d", n_pass, n_fail);
        if (n_fail == 0 && errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + BUDGET_CYCLES + MARGIN_CYCLES));
        $display("Timeout: tests did not complete within %0d cycles",
            RESET_CYCLES + BUDGET_CYCLES + MARGIN_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== hw/task_manager_top.sv ====
// Single rst_n for all stages; accelerator side is credit based with no dispatch ready
`timescale 1ns/100ps

module task_manager_top (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic                   cmd_in_valid,
    output logic                   cmd_in_ready,
    input  mgr_msg_pkg::task_cmd_t cmd_in,
    output logic                   acc_cmd_valid,
    output mgr_msg_pkg::task_cmd_t acc_cmd,
    input  logic                   acc_done_valid,
    input  mgr_msg_pkg::acc_done_t acc_done,
    input  logic                   tw_req_valid,
    output logic                   tw_req_ready,
    input  mgr_msg_pkg::tw_req_t   tw_req,
    output logic                   tw_ack_valid,
    input  logic                   tw_ack_ready,
    output mgr_msg_pkg::tw_ack_t   tw_ack
);

    logic                             disp_valid;
    mgr_msg_pkg::dispatch_rec_t       disp_rec;
    logic                             credit_valid;
    logic [mgr_cfg_pkg::ACC_BITS-1:0] credit_acc;
    logic                             tw_msg_valid;
    mgr_msg_pkg::tw_msg_u             tw_msg;

    cmd_dispatch_stage u_cmd_dispatch (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .cmd_in_valid  (cmd_in_valid),
        .cmd_in_ready  (cmd_in_ready),
        .cmd_in        (cmd_in),
        .credit_valid  (credit_valid),
        .credit_acc    (credit_acc),
        .acc_cmd_valid (acc_cmd_valid),
        .acc_cmd       (acc_cmd),
        .disp_valid    (disp_valid),
        .disp_rec      (disp_rec)
    );

    completion_stage u_completion (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .disp_valid     (disp_valid),
        .disp_rec       (disp_rec),
        .acc_done_valid (acc_done_valid),
        .acc_done       (acc_done),
        .credit_valid   (credit_valid),
        .credit_acc     (credit_acc),
        .tw_req_valid   (tw_req_valid),
        .tw_req_ready   (tw_req_ready),
        .tw_req         (tw_req),
        .tw_msg_valid   (tw_msg_valid),
        .tw_msg         (tw_msg)
    );

    taskwait_stage u_taskwait (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .tw_msg_valid (tw_msg_valid),
        .tw_msg       (tw_msg),
        .tw_ack_valid (tw_ack_valid),
        .tw_ack_ready (tw_ack_ready),
        .tw_ack       (tw_ack)
    );

endmodule

// ==== hw/taskwait_stage.sv ====
// One pending request per creator; lowest eligible creator wins, surplus finishes carry over
`timescale 1ns/100ps

module taskwait_stage (
    input  logic                 aclk,
    input  logic                 rst_n,
    input  logic                 tw_msg_valid,
    input  mgr_msg_pkg::tw_msg_u tw_msg,
    output logic                 tw_ack_valid,
    input  logic                 tw_ack_ready,
    output mgr_msg_pkg::tw_ack_t tw_ack
);

    logic [mgr_cfg_pkg::CNT_BITS-1:0]     fin_cnt [mgr_cfg_pkg::NUM_CREATORS];
    logic [mgr_cfg_pkg::CNT_BITS-1:0]     req_cnt [mgr_cfg_pkg::NUM_CREATORS];
    logic [mgr_cfg_pkg::NUM_CREATORS-1:0] pending;
    logic [mgr_cfg_pkg::NUM_CREATORS-1:0] fin_hit;
    logic [mgr_cfg_pkg::NUM_CREATORS-1:0] req_hit;
    logic [mgr_cfg_pkg::NUM_CREATORS-1:0] eligible;
    logic [mgr_cfg_pkg::NUM_CREATORS-1:0] take;
    logic [mgr_cfg_pkg::CREATOR_BITS-1:0] sel;
    logic                                 grant;
    logic                                 ack_free;

    // Decode the message by its op field
    always_comb begin
        for (int c = 0; c < mgr_cfg_pkg::NUM_CREATORS; c++) begin
            fin_hit[c] = tw_msg_valid && (tw_msg.fin.op == mgr_msg_pkg::TW_OP_FINISH)
                && (tw_msg.fin.creator_id == c[mgr_cfg_pkg::CREATOR_BITS-1:0]);
            req_hit[c] = tw_msg_valid && (tw_msg.req.op == mgr_msg_pkg::TW_OP_REQUEST)
                && (tw_msg.req.creator_id == c[mgr_cfg_pkg::CREATOR_BITS-1:0]);
            eligible[c] = pending[c] && (fin_cnt[c] >= req_cnt[c]);
        end
    end

    assign ack_free = !tw_ack_valid || tw_ack_ready;

    always_comb begin
        sel = '0;
        for (int c = mgr_cfg_pkg::NUM_CREATORS - 1; c >= 0; c--) begin
            if (eligible[c]) begin
                sel = c[mgr_cfg_pkg::CREATOR_BITS-1:0];
            end
        end
        grant = ack_free && (eligible != '0);
        for (int c = 0; c < mgr_cfg_pkg::NUM_CREATORS; c++) begin
            take[c] = grant && (sel == c[mgr_cfg_pkg::CREATOR_BITS-1:0]);
        end
    end

    always_ff @(posedge aclk) begin
        for (int c = 0; c < mgr_cfg_pkg::NUM_CREATORS; c++) begin
            if (req_hit[c]) begin
                req_cnt[c] <= tw_msg.req.count;
            end
        end
        if (grant) begin
            tw_ack <= '{creator_id: sel};
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < mgr_cfg_pkg::NUM_CREATORS; c++) begin
                fin_cnt[c] <= '0;
            end
            pending <= '0;
            tw_ack_valid <= 1'b0;
        end else begin
            for (int c = 0; c < mgr_cfg_pkg::NUM_CREATORS; c++) begin
                if (take[c]) begin
                    // A finish in the same cycle still counts
                    fin_cnt[c] <= fin_cnt[c] - req_cnt[c]
                        + {{(mgr_cfg_pkg::CNT_BITS - 1){1'b0}}, fin_hit[c]};
                    pending[c] <= 1'b0;
                end else if (fin_hit[c]) begin
                    fin_cnt[c] <= fin_cnt[c] + 1'b1;
                end
                if (req_hit[c]) begin
                    pending[c] <= 1'b1;
                end
            end
            if (grant) begin
                tw_ack_valid <= 1'b1;
            end else if (tw_ack_ready) begin
                tw_ack_valid <= 1'b0;
            end
        end
    end

    one_request_per_creator: assert property (@(posedge aclk) disable iff (!rst_n)
        tw_msg_valid && (tw_msg.req.op == mgr_msg_pkg::TW_OP_REQUEST)
        |-> !pending[tw_msg.req.creator_id]);

    for (genvar c = 0; c < mgr_cfg_pkg::NUM_CREATORS; c++) begin : g_cnt_chk
        fin_cnt_no_wrap: assert property (@(posedge aclk) disable iff (!rst_n)
            fin_hit[c] && !take[c] |-> fin_cnt[c] != '1);
    end

endmodule

// ==== hw/completion_stage.sv ====
// Finish has priority over a taskwait request; acc_done must only name a busy accelerator
`timescale 1ns/100ps

module completion_stage (
    input  logic                             aclk,
    input  logic                             rst_n,
    input  logic                             disp_valid,
    input  mgr_msg_pkg::dispatch_rec_t       disp_rec,
    input  logic                             acc_done_valid,
    input  mgr_msg_pkg::acc_done_t           acc_done,
    output logic                             credit_valid,
    output logic [mgr_cfg_pkg::ACC_BITS-1:0] credit_acc,
    input  logic                             tw_req_valid,
    output logic                             tw_req_ready,
    input  mgr_msg_pkg::tw_req_t             tw_req,
    output logic                             tw_msg_valid,
    output mgr_msg_pkg::tw_msg_u             tw_msg
);

    // Creator of the task in flight on each accelerator
    logic [mgr_cfg_pkg::CREATOR_BITS-1:0] owner [mgr_cfg_pkg::NUM_ACCS];
    logic [mgr_cfg_pkg::NUM_ACCS-1:0]     busy;
    logic                                 req_take;
    mgr_msg_pkg::tw_msg_u                 msg_next;

    assign tw_req_ready = !acc_done_valid;
    assign req_take = tw_req_valid && tw_req_ready;

    always_comb begin
        msg_next = '0;
        if (acc_done_valid) begin
            msg_next.fin.op = mgr_msg_pkg::TW_OP_FINISH;
            msg_next.fin.creator_id = owner[acc_done.acc_id];
            msg_next.fin.acc_id = acc_done.acc_id;
        end else begin
            msg_next.req.op = mgr_msg_pkg::TW_OP_REQUEST;
            msg_next.req.creator_id = tw_req.creator_id;
            msg_next.req.count = tw_req.count;
        end
    end

    always_ff @(posedge aclk) begin
        if (disp_valid) begin
            owner[disp_rec.acc_id] <= disp_rec.creator_id;
        end
        if (acc_done_valid || req_take) begin
            tw_msg <= msg_next;
        end
        if (acc_done_valid) begin
            credit_acc <= acc_done.acc_id;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
            credit_valid <= 1'b0;
            tw_msg_valid <= 1'b0;
        end else begin
            credit_valid <= acc_done_valid;
            tw_msg_valid <= acc_done_valid || req_take;
            if (acc_done_valid) begin
                busy[acc_done.acc_id] <= 1'b0;
            end
            if (disp_valid) begin
                busy[disp_rec.acc_id] <= 1'b1;
            end
        end
    end

    done_while_busy: assert property (@(posedge aclk) disable iff (!rst_n)
        acc_done_valid |-> busy[acc_done.acc_id]);

endmodule

// ==== hw/cmd_dispatch_stage.sv ====
// One credit per accelerator and no dispatch ready; cmd_in_ready depends on the presented acc_id
`timescale 1ns/100ps

module cmd_dispatch_stage (
    input  logic                             aclk,
    input  logic                             rst_n,
    input  logic                             cmd_in_valid,
    output logic                             cmd_in_ready,
    input  mgr_msg_pkg::task_cmd_t           cmd_in,
    input  logic                             credit_valid,
    input  logic [mgr_cfg_pkg::ACC_BITS-1:0] credit_acc,
    output logic                             acc_cmd_valid,
    output mgr_msg_pkg::task_cmd_t           acc_cmd,
    output logic                             disp_valid,
    output mgr_msg_pkg::dispatch_rec_t       disp_rec
);

    mgr_msg_pkg::task_cmd_t q_mem [mgr_cfg_pkg::NUM_ACCS][mgr_cfg_pkg::SUBQUEUE_LEN];

    // Extra wrap bit tells full from empty
    logic [mgr_cfg_pkg::SUBQUEUE_BITS:0] wr_ptr [mgr_cfg_pkg::NUM_ACCS];
    logic [mgr_cfg_pkg::SUBQUEUE_BITS:0] rd_ptr [mgr_cfg_pkg::NUM_ACCS];
    logic [mgr_cfg_pkg::SUBQUEUE_BITS:0] fill   [mgr_cfg_pkg::NUM_ACCS];

    logic [mgr_cfg_pkg::NUM_ACCS-1:0] credit;
    logic [mgr_cfg_pkg::NUM_ACCS-1:0] full;
    logic [mgr_cfg_pkg::NUM_ACCS-1:0] can_go;
    logic [mgr_cfg_pkg::ACC_BITS-1:0] rr_ptr;
    logic [mgr_cfg_pkg::ACC_BITS-1:0] pick;
    logic                             pick_valid;
    logic                             push;

    always_comb begin
        for (int a = 0; a < mgr_cfg_pkg::NUM_ACCS; a++) begin
            fill[a] = wr_ptr[a] - rd_ptr[a];
            // MSB of fill is set only at exactly SUBQUEUE_LEN
            full[a] = fill[a][mgr_cfg_pkg::SUBQUEUE_BITS];
            can_go[a] = (fill[a] != '0) && credit[a];
        end
    end

    assign cmd_in_ready = !full[cmd_in.acc_id];
    assign push = cmd_in_valid && cmd_in_ready;

    // Round-robin search starting at rr_ptr
    always_comb begin
        logic [mgr_cfg_pkg::ACC_BITS-1:0] idx;
        pick = rr_ptr;
        pick_valid = 1'b0;
        for (int i = 0; i < mgr_cfg_pkg::NUM_ACCS; i++) begin
            idx = rr_ptr + i[mgr_cfg_pkg::ACC_BITS-1:0];
            if (!pick_valid && can_go[idx]) begin
                pick = idx;
                pick_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            q_mem[cmd_in.acc_id][wr_ptr[cmd_in.acc_id][mgr_cfg_pkg::SUBQUEUE_BITS-1:0]] <= cmd_in;
        end
        if (pick_valid) begin
            acc_cmd <= q_mem[pick][rd_ptr[pick][mgr_cfg_pkg::SUBQUEUE_BITS-1:0]];
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int a = 0; a < mgr_cfg_pkg::NUM_ACCS; a++) begin
                wr_ptr[a] <= '0;
                rd_ptr[a] <= '0;
            end
            credit <= '1;
            rr_ptr <= '0;
            acc_cmd_valid <= 1'b0;
        end else begin
            acc_cmd_valid <= pick_valid;
            if (push) begin
                wr_ptr[cmd_in.acc_id] <= wr_ptr[cmd_in.acc_id] + 1'b1;
            end
            if (pick_valid) begin
                rd_ptr[pick] <= rd_ptr[pick] + 1'b1;
                credit[pick] <= 1'b0;
                rr_ptr <= pick + 1'b1;
            end
            // Never the same accelerator as the pick, its credit is still clear
            if (credit_valid) begin
                credit[credit_acc] <= 1'b1;
            end
        end
    end

    assign disp_valid = acc_cmd_valid;
    assign disp_rec = '{acc_id: acc_cmd.acc_id, creator_id: acc_cmd.creator_id};

    // Completion stage must not hand back a credit that was never spent
    credit_return_spent: assert property (@(posedge aclk) disable iff (!rst_n)
        credit_valid |-> !credit[credit_acc]);

    for (genvar a = 0; a < mgr_cfg_pkg::NUM_ACCS; a++) begin : g_fill_chk
        fill_in_bounds: assert property (@(posedge aclk) disable iff (!rst_n)
            int'(fill[a]) <= mgr_cfg_pkg::SUBQUEUE_LEN);
    end

endmodule

// ==== hw/mgr_msg_pkg.sv ====
// Stage messages; CNT_BITS must exceed ACC_BITS so both taskwait views have equal width
package mgr_msg_pkg;

    typedef struct packed {
        logic [mgr_cfg_pkg::ACC_BITS-1:0]     acc_id;
        logic [mgr_cfg_pkg::CREATOR_BITS-1:0] creator_id;
        logic [mgr_cfg_pkg::TASK_ID_BITS-1:0] task_id;
    } task_cmd_t;

    typedef struct packed {
        logic [mgr_cfg_pkg::ACC_BITS-1:0] acc_id;
    } acc_done_t;

    typedef struct packed {
        logic [mgr_cfg_pkg::CREATOR_BITS-1:0] creator_id;
        logic [mgr_cfg_pkg::CNT_BITS-1:0]     count;
    } tw_req_t;

    typedef struct packed {
        logic [mgr_cfg_pkg::CREATOR_BITS-1:0] creator_id;
    } tw_ack_t;

    // Who owns the task just sent to an accelerator
    typedef struct packed {
        logic [mgr_cfg_pkg::ACC_BITS-1:0]     acc_id;
        logic [mgr_cfg_pkg::CREATOR_BITS-1:0] creator_id;
    } dispatch_rec_t;

    typedef enum logic {
        TW_OP_FINISH  = 1'b0,
        TW_OP_REQUEST = 1'b1
    } tw_op_e;

    typedef struct packed {
        tw_op_e                                          op;
        logic [mgr_cfg_pkg::CREATOR_BITS-1:0]            creator_id;
        logic [mgr_cfg_pkg::CNT_BITS-mgr_cfg_pkg::ACC_BITS-1:0] pad;
        logic [mgr_cfg_pkg::ACC_BITS-1:0]                acc_id;
    } tw_fin_view_t;

    typedef struct packed {
        tw_op_e                               op;
        logic [mgr_cfg_pkg::CREATOR_BITS-1:0] creator_id;
        logic [mgr_cfg_pkg::CNT_BITS-1:0]     count;
    } tw_req_view_t;

    // Op field sits at the same position in both views
    typedef union packed {
        tw_fin_view_t fin;
        tw_req_view_t req;
    } tw_msg_u;

endpackage

// ==== hw/mgr_cfg_pkg.sv ====
// Fixed manager sizes; NUM_ACCS and SUBQUEUE_LEN must stay powers of two
package mgr_cfg_pkg;

    // Accelerators behind the dispatch port
    localparam int NUM_ACCS = 4;

    // Accelerator index, also the round-robin pointer width
    localparam int ACC_BITS = $clog2(NUM_ACCS);

    // Commands buffered per accelerator
    localparam int SUBQUEUE_LEN = 8;

    // Pointer into one subqueue, without the wrap bit
    localparam int SUBQUEUE_BITS = $clog2(SUBQUEUE_LEN);

    // Creators that may issue taskwait requests
    localparam int NUM_CREATORS = 4;

    localparam int CREATOR_BITS = $clog2(NUM_CREATORS);

    // Opaque to the manager, passed through to the accelerator
    localparam int TASK_ID_BITS = 16;

    // Finish counters and requested counts share this width
    localparam int CNT_BITS = 8;

endpackage
